//--- credits_pkg.sv
`default_nettype none

package credits_pkg;

    typedef logic [13:0] addr_t;        // AXI byte address
    typedef logic [31:0] word_t;
    typedef logic [8:0]  msg_cell_t;    // {palette, char code}
    typedef logic [7:0]  font_row_t;    // msb is the leftmost pixel
    typedef logic [9:0]  font_addr_t;   // {char code, glyph row}
    typedef logic [8:0]  hpos_t;
    typedef logic [9:0]  scroll_t;      // up to four pages of 256 lines
    typedef logic [11:0] pal_colour_t;  // 4 bits per component

    ////////////////////
    // register map
    localparam addr_t REG_CTRL   = 14'h0000;
    localparam addr_t REG_STATUS = 14'h0004;
    localparam addr_t MSG_BASE   = 14'h1000;   // one word per cell
    localparam addr_t FONT_BASE  = 14'h2000;   // one word per glyph row

    // control register bits
    localparam int CTRL_ENABLE = 0;
    localparam int CTRL_HIDE   = 1;
    localparam int CTRL_FAST   = 2;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    ////////////////////
    // default palette
    localparam pal_colour_t DEF_PAL0 = 12'hf00;  // red
    localparam pal_colour_t DEF_PAL1 = 12'h0f0;  // green
    localparam pal_colour_t DEF_PAL2 = 12'h00f;  // blue
    localparam pal_colour_t DEF_PAL3 = 12'hfff;  // white

endpackage

`default_nettype wire

//--- credits_dp_ram.sv
`timescale 1ns/1ns
`default_nettype none

// port a belongs to the host, port b to the video fetch
module credits_dp_ram #(
    parameter int DW = 8,
    parameter int AW = 10
) (
    input  wire logic          clk,
    // host port
    input  wire logic [AW-1:0] a_addr,
    input  wire logic          a_we,
    input  wire logic [DW-1:0] a_din,
    output logic      [DW-1:0] a_dout,
    // video port, read only
    input  wire logic [AW-1:0] b_addr,
    output logic      [DW-1:0] b_dout
);

    logic [DW-1:0] mem [0:2**AW-1];

    always_ff @(posedge clk) begin
        if (a_we) begin
            mem[a_addr] <= a_din;
        end
        a_dout <= mem[a_addr];  // old data on a write
    end

    always_ff @(posedge clk) begin
        b_dout <= mem[b_addr];
    end

endmodule

`default_nettype wire

//--- credits_axil_regs.sv
`timescale 1ns/1ns
`default_nettype none

module credits_axil_regs #(
    parameter int  PAGES = 1,
    localparam int MSGW  = PAGES == 1 ? 10 : (PAGES == 2 ? 11 : 12)
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    // write channels
    input  wire credits_pkg::addr_t     s_awaddr,
    input  wire logic                   s_awvalid,
    output logic                        s_awready,
    input  wire credits_pkg::word_t     s_wdata,
    input  wire logic [3:0]             s_wstrb,
    input  wire logic                   s_wvalid,
    output logic                        s_wready,
    output logic [1:0]                  s_bresp,
    output logic                        s_bvalid,
    input  wire logic                   s_bready,
    // read channels
    input  wire credits_pkg::addr_t     s_araddr,
    input  wire logic                   s_arvalid,
    output logic                        s_arready,
    output credits_pkg::word_t          s_rdata,
    output logic [1:0]                  s_rresp,
    output logic                        s_rvalid,
    input  wire logic                   s_rready,
    // host ports of the RAMs
    output logic [MSGW-1:0]             msg_addr,
    output logic                        msg_we,
    output credits_pkg::msg_cell_t      msg_din,
    input  wire credits_pkg::msg_cell_t msg_dout,
    output credits_pkg::font_addr_t     font_addr,
    output logic                        font_we,
    output credits_pkg::font_row_t      font_din,
    input  wire credits_pkg::font_row_t font_dout,
    // control
    output logic                        enable,
    output logic                        hide,
    output logic                        fast_scroll,
    input  wire credits_pkg::scroll_t   scroll_pos
);

    import credits_pkg::*;

    typedef enum logic [1:0] {RD_IDLE, RD_WAIT_RAM, RD_RESPOND} rd_state_t;

    rd_state_t rd_state;
    logic      live;              // low for the first cycle out of reset
    logic      aw_full, w_full;
    addr_t     aw_addr, ar_addr;
    word_t     w_data;
    logic      w_byte0;
    logic      do_write, ar_take;

    function automatic logic in_msg(addr_t a);
        return a[13:12] == MSG_BASE[13:12];
    endfunction

    function automatic logic in_font(addr_t a);
        return a[13:12] == FONT_BASE[13:12];
    endfunction

    function automatic logic mapped(addr_t a);
        return in_msg(a) || in_font(a) || a == REG_CTRL || a == REG_STATUS;
    endfunction

    assign s_awready = live && !aw_full && !s_bvalid;
    assign s_wready  = live && !w_full && !s_bvalid;
    assign do_write  = aw_full && w_full;
    assign s_arready = live && rd_state == RD_IDLE && !do_write; // write owns the RAM port
    assign ar_take   = s_arvalid && s_arready;
    assign s_rvalid  = rd_state == RD_RESPOND;

    ////////////////////
    // RAM host ports
    assign msg_addr  = MSGW'(do_write ? aw_addr[11:2] : s_araddr[11:2]);
    assign font_addr = do_write ? aw_addr[11:2] : s_araddr[11:2];
    assign msg_din   = w_data[8:0];
    assign font_din  = w_data[7:0];
    assign msg_we    = do_write && w_byte0 && in_msg(aw_addr);
    assign font_we   = do_write && w_byte0 && in_font(aw_addr);

    ////////////////////
    // write path
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            live        <= 1'b0;
            aw_full     <= 1'b0;
            w_full      <= 1'b0;
            s_bvalid    <= 1'b0;
            s_bresp     <= RESP_OKAY;
            enable      <= 1'b0;
            hide        <= 1'b0;
            fast_scroll <= 1'b0;
        end else begin
            live <= 1'b1;
            if (s_awvalid && s_awready) aw_full <= 1'b1;
            if (s_wvalid && s_wready) w_full <= 1'b1;
            if (do_write) begin
                aw_full  <= 1'b0;
                w_full   <= 1'b0;
                s_bvalid <= 1'b1;
                s_bresp  <= mapped(aw_addr) ? RESP_OKAY : RESP_SLVERR;
                if (aw_addr == REG_CTRL && w_byte0) begin
                    enable      <= w_data[CTRL_ENABLE];
                    hide        <= w_data[CTRL_HIDE];
                    fast_scroll <= w_data[CTRL_FAST];
                end
            end else if (s_bready) begin
                s_bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s_awvalid && s_awready) aw_addr <= s_awaddr;
        if (s_wvalid && s_wready) begin
            w_data  <= s_wdata;
            w_byte0 <= s_wstrb[0];  // only the low byte carries data
        end
    end

    ////////////////////
    // read path
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_state <= RD_IDLE;
        end else begin
            case (rd_state)
                RD_IDLE:     if (ar_take) rd_state <= RD_WAIT_RAM;
                RD_WAIT_RAM: rd_state <= RD_RESPOND;  // RAM data valid now
                RD_RESPOND:  if (s_rready) rd_state <= RD_IDLE;
                default:     rd_state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ar_take) ar_addr <= s_araddr;
        if (rd_state == RD_WAIT_RAM) begin
            s_rresp <= mapped(ar_addr) ? RESP_OKAY : RESP_SLVERR;
            if (in_msg(ar_addr)) s_rdata <= word_t'(msg_dout);
            else if (in_font(ar_addr)) s_rdata <= word_t'(font_dout);
            else if (ar_addr == REG_CTRL) s_rdata <= word_t'({fast_scroll, hide, enable});
            else if (ar_addr == REG_STATUS) s_rdata <= word_t'(scroll_pos);
            else s_rdata <= '0;
        end
    end

    // response held steady under back-pressure
    assert property (@(posedge clk) disable iff (rst)
        s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata) && $stable(s_rresp));

    // one RAM write per accepted AW/W pair, never while a B response waits
    assert property (@(posedge clk) disable iff (rst)
        (msg_we || font_we) |-> !s_bvalid ##1 !(msg_we || font_we));

endmodule

`default_nettype wire

//--- credits_scroller.sv
`timescale 1ns/1ns
`default_nettype none

module credits_scroller #(
    parameter int  PAGES  = 1,
    parameter int  SPEED  = 2,
    parameter bit  BLKPOL = 1'b1,
    localparam int MSGW   = PAGES == 1 ? 10 : (PAGES == 2 ? 11 : 12)
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   pxl_cen,
    input  wire logic                   hb,
    input  wire logic                   vb,
    input  wire logic                   enable,
    input  wire logic                   fast_scroll,
    // video fetch
    output logic [MSGW-1:0]             vmsg_addr,
    input  wire credits_pkg::msg_cell_t vmsg_cell,
    output credits_pkg::font_addr_t     vfont_addr,
    input  wire credits_pkg::font_row_t vfont_row,
    // to host and mixer
    output credits_pkg::scroll_t        scroll_pos,
    output logic                        pxl_bit,
    output logic [1:0]                  pxl_pal,
    output logic                        row_parity
);

    import credits_pkg::*;

    localparam scroll_t LAST = scroll_t'(PAGES * 256 - 1);

    logic       hb_a, vb_a;      // active high blanking
    logic       last_hb, last_vb, last_en;
    hpos_t      hn;
    scroll_t    vline;           // message line on this raster line
    logic [7:0] frame_cnt;
    msg_cell_t  cell_q;
    font_row_t  shift;

    function automatic scroll_t next_line(scroll_t l);
        return l == LAST ? '0 : l + 1'b1;  // message wraps
    endfunction

    assign hb_a = BLKPOL ? hb : ~hb;
    assign vb_a = BLKPOL ? vb : ~vb;

    ////////////////////
    // beam and scroll counters
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hn         <= '0;
            vline      <= '0;
            frame_cnt  <= '0;
            scroll_pos <= '0;
            last_hb    <= 1'b0;
            last_vb    <= 1'b0;
            last_en    <= 1'b0;
        end else if (pxl_cen) begin
            last_hb <= hb_a;
            last_vb <= vb_a;
            last_en <= enable;
            hn      <= hb_a ? '0 : hn + 1'b1;
            if (vb_a) vline <= scroll_pos;  // top line of the next frame
            else if (hb_a && !last_hb) vline <= next_line(vline);
            if (enable && !last_en) begin
                scroll_pos <= '0;
                frame_cnt  <= '0;
            end else if (enable && vb_a && !last_vb) begin
                if (frame_cnt == SPEED || fast_scroll) begin
                    scroll_pos <= next_line(scroll_pos);
                    frame_cnt  <= '0;
                end else begin
                    frame_cnt <= frame_cnt + 1'b1;
                end
            end
        end
    end

    ////////////////////
    // fetch pipeline
    // strobe 1 message address, strobe 2 cell, strobe 3 glyph into the shifter
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            // next column, so the glyph lands at pixel 1 of its own cell
            // column 0 is fetched during blanking
            vmsg_addr <= {vline[MSGW-3:3], hb_a ? 5'd0 : hn[7:3] + 5'd1};
            cell_q    <= vmsg_cell;
            if (hn[2:0] == 3'd1) begin
                shift   <= vfont_row;
                pxl_pal <= cell_q[8:7];
            end else begin
                shift <= shift << 1;
            end
        end
    end

    assign vfont_addr = {cell_q[6:0], vline[2:0]};
    assign pxl_bit    = shift[7];
    assign row_parity = vline[7];

    assert property (@(posedge clk) disable iff (rst)
        int'(scroll_pos) < PAGES * 256);

endmodule

`default_nettype wire

//--- credits_mixer.sv
`timescale 1ns/1ns
`default_nettype none

module credits_mixer #(
    parameter int                       COLW   = 4,
    parameter bit                       BLKPOL = 1'b1,
    parameter credits_pkg::pal_colour_t PAL0   = credits_pkg::DEF_PAL0,
    parameter credits_pkg::pal_colour_t PAL1   = credits_pkg::DEF_PAL1,
    parameter credits_pkg::pal_colour_t PAL2   = credits_pkg::DEF_PAL2,
    parameter credits_pkg::pal_colour_t PAL3   = credits_pkg::DEF_PAL3
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              pxl_cen,
    // picture in
    input  wire logic              hb_in,
    input  wire logic              vb_in,
    input  wire logic [3*COLW-1:0] rgb_in,
    // control
    input  wire logic              enable,
    input  wire logic              hide,
    // text from the scroller
    input  wire logic              pxl_bit,
    input  wire logic [1:0]        pxl_pal,
    input  wire logic              row_parity,
    // picture out
    output logic                   hb_out,
    output logic                   vb_out,
    output logic      [3*COLW-1:0] rgb_out
);

    import credits_pkg::*;

    logic              show;
    logic              blank;
    logic [3*COLW-1:0] dim, pal_rgb;

    // widen 4-bit components by repeating their top bits
    function automatic logic [3*COLW-1:0] extend(pal_colour_t c);
        logic [7:0]        wide;
        logic [3*COLW-1:0] res;
        for (int i = 0; i < 3; i++) begin
            wide = {c[4*i +: 4], c[4*i +: 4]};
            res[COLW*i +: COLW] = wide[7 -: COLW];
        end
        return res;
    endfunction

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            dim[COLW*i +: COLW] = rgb_in[COLW*i +: COLW] >> 1;  // half brightness
        end
    end

    always_comb begin
        case (pxl_pal)
            2'd0:    pal_rgb = extend(PAL0);
            2'd1:    pal_rgb = extend(PAL1);
            2'd2:    pal_rgb = extend(PAL2);
            default: pal_rgb = extend(PAL3);
        endcase
    end

    assign blank = hb_in == BLKPOL || vb_in == BLKPOL;

    ////////////////////
    // show / hide
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            show <= 1'b0;
        end else if (pxl_cen) begin
            show <= enable && !hide;
        end
    end

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            hb_out <= hb_in;
            vb_out <= vb_in;
            if (!show) rgb_out <= rgb_in;      // passthrough
            else if (blank) rgb_out <= '0;
            else if (pxl_bit) rgb_out <= pal_rgb;
            else rgb_out <= dim;
        end
    end

    // text rows move on only while the picture is blanked
    assert property (@(posedge clk) disable iff (rst)
        $changed(row_parity) |-> $past(blank));

endmodule

`default_nettype wire

//--- credits_top.sv
`timescale 1ns/1ns
`default_nettype none

module credits_top #(
    parameter int                       PAGES  = 1,
    parameter int                       COLW   = 4,
    parameter int                       SPEED  = 2,
    parameter bit                       BLKPOL = 1'b1,
    parameter credits_pkg::pal_colour_t PAL0   = credits_pkg::DEF_PAL0,
    parameter credits_pkg::pal_colour_t PAL1   = credits_pkg::DEF_PAL1,
    parameter credits_pkg::pal_colour_t PAL2   = credits_pkg::DEF_PAL2,
    parameter credits_pkg::pal_colour_t PAL3   = credits_pkg::DEF_PAL3,
    localparam int                      MSGW   = PAGES == 1 ? 10 : (PAGES == 2 ? 11 : 12)
) (
    input  wire logic               clk,
    input  wire logic               rst,
    // AXI4-Lite slave
    input  wire credits_pkg::addr_t s_awaddr,
    input  wire logic               s_awvalid,
    output logic                    s_awready,
    input  wire credits_pkg::word_t s_wdata,
    input  wire logic [3:0]         s_wstrb,
    input  wire logic               s_wvalid,
    output logic                    s_wready,
    output logic [1:0]              s_bresp,
    output logic                    s_bvalid,
    input  wire logic               s_bready,
    input  wire credits_pkg::addr_t s_araddr,
    input  wire logic               s_arvalid,
    output logic                    s_arready,
    output credits_pkg::word_t      s_rdata,
    output logic [1:0]              s_rresp,
    output logic                    s_rvalid,
    input  wire logic               s_rready,
    // video
    input  wire logic               pxl_cen,
    input  wire logic               hb,
    input  wire logic               vb,
    input  wire logic [3*COLW-1:0]  rgb_in,
    output logic                    hb_out,
    output logic                    vb_out,
    output logic      [3*COLW-1:0]  rgb_out
);

    import credits_pkg::*;

    logic [MSGW-1:0] msg_addr, vmsg_addr;
    logic            msg_we, font_we;
    msg_cell_t       msg_din, msg_dout, vmsg_cell;
    font_addr_t      font_addr, vfont_addr;
    font_row_t       font_din, font_dout, vfont_row;
    logic            enable, hide, fast_scroll;
    scroll_t         scroll_pos;
    logic            pxl_bit, row_parity;
    logic [1:0]      pxl_pal;

    credits_axil_regs #(.PAGES(PAGES)) u_regs (
        .clk, .rst,
        .s_awaddr, .s_awvalid, .s_awready,
        .s_wdata, .s_wstrb, .s_wvalid, .s_wready,
        .s_bresp, .s_bvalid, .s_bready,
        .s_araddr, .s_arvalid, .s_arready,
        .s_rdata, .s_rresp, .s_rvalid, .s_rready,
        .msg_addr, .msg_we, .msg_din, .msg_dout,
        .font_addr, .font_we, .font_din, .font_dout,
        .enable, .hide, .fast_scroll, .scroll_pos
    );

    credits_dp_ram #(.DW($bits(msg_cell_t)), .AW(MSGW)) u_msg (
        .clk,
        .a_addr(msg_addr), .a_we(msg_we), .a_din(msg_din), .a_dout(msg_dout),
        .b_addr(vmsg_addr), .b_dout(vmsg_cell)
    );

    credits_dp_ram #(.DW($bits(font_row_t)), .AW($bits(font_addr_t))) u_font (
        .clk,
        .a_addr(font_addr), .a_we(font_we), .a_din(font_din), .a_dout(font_dout),
        .b_addr(vfont_addr), .b_dout(vfont_row)
    );

    credits_scroller #(.PAGES(PAGES), .SPEED(SPEED), .BLKPOL(BLKPOL)) u_scroller (
        .clk, .rst, .pxl_cen, .hb, .vb, .enable, .fast_scroll,
        .vmsg_addr, .vmsg_cell, .vfont_addr, .vfont_row,
        .scroll_pos, .pxl_bit, .pxl_pal, .row_parity
    );

    credits_mixer #(
        .COLW(COLW), .BLKPOL(BLKPOL),
        .PAL0(PAL0), .PAL1(PAL1), .PAL2(PAL2), .PAL3(PAL3)
    ) u_mixer (
        .clk, .rst, .pxl_cen,
        .hb_in(hb), .vb_in(vb), .rgb_in,
        .enable, .hide, .pxl_bit, .pxl_pal, .row_parity,
        .hb_out, .vb_out, .rgb_out
    );

endmodule

`default_nettype wire

//--- tb_credits.sv
`timescale 1ns/1ns
`default_nettype none

module tb_credits;

    import credits_pkg::*;

    localparam int COLW         = 4;
    localparam int PAGES        = 1;
    localparam int SPEED        = 2;
    localparam int CLK_NS       = 4;
    localparam int H_ACTIVE     = 64;
    localparam int H_TOTAL      = 80;
    localparam int V_ACTIVE     = 40;
    localparam int V_TOTAL      = 48;
    localparam int FRAME_CYCLES = 2 * H_TOTAL * V_TOTAL;  // one strobe every second cycle
    localparam int TEST_FRAMES  = 24;                     // sequence below needs about 20
    localparam int WATCHDOG_NS  = (TEST_FRAMES * FRAME_CYCLES + 2000) * CLK_NS;
    localparam int CELLS        = PAGES * 1024;           // 32 rows of 32 cells per page
    localparam int TEXT_LEAD    = 2;      // glyph loads at pixel 1, columns 0 and 1 stay dim
    localparam logic [11:0] PAL2_RGB = 12'h00f;          // blue, no widening at COLW 4

    typedef enum logic [1:0] {M_OFF, M_PASS, M_DIM, M_TEXT} check_mode_t;

    logic        clk, rst;
    addr_t       s_awaddr, s_araddr;
    logic        s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid, s_bready;
    logic        s_arvalid, s_arready, s_rvalid, s_rready;
    word_t       s_wdata, s_rdata;
    logic [3:0]  s_wstrb;
    logic [1:0]  s_bresp, s_rresp;
    logic        pxl_cen, hb, vb, hb_out, vb_out;
    logic [11:0] rgb_in, rgb_out;

    check_mode_t mode;
    int          src_x, src_y, prev_x;
    logic [31:0] seed;
    logic        prev_cen, prev_hb, prev_vb;
    logic [11:0] prev_rgb;
    int          check_errors, stream_errors, hold_errors;

    credits_top #(.PAGES(PAGES), .COLW(COLW), .SPEED(SPEED)) u_dut (
        .clk, .rst,
        .s_awaddr, .s_awvalid, .s_awready, .s_wdata, .s_wstrb, .s_wvalid, .s_wready,
        .s_bresp, .s_bvalid, .s_bready,
        .s_araddr, .s_arvalid, .s_arready, .s_rdata, .s_rresp, .s_rvalid, .s_rready,
        .pxl_cen, .hb, .vb, .rgb_in, .hb_out, .vb_out, .rgb_out
    );

    always #(CLK_NS / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // each 4-bit component shifted right, borrow from the next one masked off
    function automatic logic [11:0] halve(input logic [11:0] c);
        return (c >> 1) & 12'h777;
    endfunction

    ////////////////////
    // video source
    always @(posedge clk) begin
        #1;
        if (pxl_cen) begin
            pxl_cen = 1'b0;
            src_x   = (src_x == H_TOTAL - 1) ? 0 : src_x + 1;
            if (src_x == 0) src_y = (src_y == V_TOTAL - 1) ? 0 : src_y + 1;
            hb      = src_x >= H_ACTIVE;
            vb      = src_y >= V_ACTIVE;
            seed    = lcg_next(seed);
            rgb_in  = seed[27:16];
        end else begin
            pxl_cen = 1'b1;
        end
    end

    // what the DUT saw at the last edge
    always @(posedge clk) begin
        prev_cen <= pxl_cen;
        prev_hb  <= hb;
        prev_vb  <= vb;
        prev_rgb <= rgb_in;
        prev_x   <= src_x;
    end

    ////////////////////
    // stream checks, taken mid cycle
    pass_check: assert property (@(negedge clk) disable iff (rst)
        prev_cen && mode == M_PASS |-> rgb_out == prev_rgb && hb_out == prev_hb
            && vb_out == prev_vb)
        else begin
            stream_errors++;
            $display("ERROR passthrough: expected %h %b %b actual %h %b %b",
                prev_rgb, prev_hb, prev_vb, rgb_out, hb_out, vb_out);
        end

    blank_check: assert property (@(negedge clk) disable iff (rst)
        prev_cen && (mode == M_DIM || mode == M_TEXT) && (prev_hb || prev_vb)
            |-> rgb_out == '0)
        else begin
            stream_errors++;
            $display("ERROR blanking: expected %h actual %h", 12'h000, rgb_out);
        end

    dim_check: assert property (@(negedge clk) disable iff (rst)
        prev_cen && mode == M_DIM && !prev_hb && !prev_vb |-> rgb_out == halve(prev_rgb))
        else begin
            stream_errors++;
            $display("ERROR dimmed picture: expected %h actual %h", halve(prev_rgb), rgb_out);
        end

    text_check: assert property (@(negedge clk) disable iff (rst)
        prev_cen && mode == M_TEXT && !prev_hb && !prev_vb && prev_x >= TEXT_LEAD
            |-> rgb_out == PAL2_RGB)
        else begin
            stream_errors++;
            $display("ERROR solid text: expected %h actual %h", PAL2_RGB, rgb_out);
        end

    b_hold: assert property (@(posedge clk) disable iff (rst)
        s_bvalid && !s_bready |=> s_bvalid && $stable(s_bresp))
        else begin
            hold_errors++;
            $display("write response dropped or changed while BREADY was low");
        end

    r_hold: assert property (@(posedge clk) disable iff (rst)
        s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata) && $stable(s_rresp))
        else begin
            hold_errors++;
            $display("read response dropped or changed while RREADY was low");
        end

    ////////////////////
    // bus tasks
    task automatic check_word(input string name, input word_t exp, input word_t act);
        assert (act == exp) else begin
            check_errors++;
            $display("ERROR %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic axi_write(input addr_t addr, input word_t data, input int hold,
                             output logic [1:0] resp);
        logic aw_done, w_done;
        aw_done = 1'b0;
        w_done  = 1'b0;
        @(posedge clk);
        #1;
        s_awaddr  = addr;
        s_awvalid = 1'b1;
        s_wdata   = data;
        s_wstrb   = 4'hf;
        s_wvalid  = 1'b1;
        s_bready  = hold == 0;
        while (!aw_done || !w_done) begin
            @(posedge clk);
            if (s_awvalid && s_awready) aw_done = 1'b1;
            if (s_wvalid && s_wready) w_done = 1'b1;
            #1;
            if (aw_done) s_awvalid = 1'b0;
            if (w_done) s_wvalid = 1'b0;
        end
        @(posedge clk);
        while (!s_bvalid) @(posedge clk);
        resp = s_bresp;
        if (hold > 0) begin
            repeat (hold) @(posedge clk);  // response must sit still meanwhile
            #1;
            s_bready = 1'b1;
            @(posedge clk);
        end
        #1;
        s_bready = 1'b0;
    endtask

    task automatic axi_read(input addr_t addr, input int hold,
                            output word_t data, output logic [1:0] resp);
        @(posedge clk);
        #1;
        s_araddr  = addr;
        s_arvalid = 1'b1;
        s_rready  = hold == 0;
        @(posedge clk);
        while (!s_arready) @(posedge clk);
        #1;
        s_arvalid = 1'b0;
        @(posedge clk);
        while (!s_rvalid) @(posedge clk);
        data = s_rdata;
        resp = s_rresp;
        if (hold > 0) begin
            repeat (hold) @(posedge clk);
            #1;
            s_rready = 1'b1;
            @(posedge clk);
        end
        #1;
        s_rready = 1'b0;
    endtask

    task automatic load_glyph(input int code, input logic [7:0] row_bits);
        logic [1:0] resp;
        for (int r = 0; r < 8; r++) begin
            axi_write(FONT_BASE + addr_t'(4 * (code * 8 + r)), word_t'(row_bits), 0, resp);
            check_word("font write bresp", word_t'(RESP_OKAY), word_t'(resp));
        end
    endtask

    // palette either fixed or folded from all address bits
    task automatic fill_cells(input logic [6:0] code, input logic [1:0] pal, input bit fold);
        logic [1:0] resp;
        logic [9:0] a;
        logic [1:0] p;
        for (int i = 0; i < CELLS; i++) begin
            a = 10'(i);
            p = fold ? (a[1:0] ^ a[3:2] ^ a[5:4] ^ a[7:6] ^ a[9:8]) : pal;
            axi_write(MSG_BASE + addr_t'(4 * i), word_t'({p, code}), 0, resp);
            check_word("cell write bresp", word_t'(RESP_OKAY), word_t'(resp));
        end
    endtask

    task automatic wait_frame();
        @(negedge vb);
        @(posedge clk);
        #1;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the test sequence never finished",
            WATCHDOG_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

    ////////////////////
    // main sequence
    initial begin
        logic [1:0] resp;
        word_t      rdata;
        word_t      pos [0:6];
        clk = 1'b0;
        rst = 1'b1;
        s_awaddr = '0;
        s_awvalid = 1'b0;
        s_wdata = '0;
        s_wstrb = '0;
        s_wvalid = 1'b0;
        s_bready = 1'b0;
        s_araddr = '0;
        s_arvalid = 1'b0;
        s_rready = 1'b0;
        pxl_cen = 1'b0;
        hb = 1'b0;
        vb = 1'b0;
        rgb_in = '0;
        src_x = 0;
        src_y = 0;
        seed = 32'h7bf1f749;
        mode = M_OFF;
        check_errors = 0;
        stream_errors = 0;
        hold_errors = 0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        mode = M_PASS;
        wait_frame();

        // register, RAM windows and unmapped space
        axi_write(REG_CTRL, 32'h6, 0, resp);
        check_word("ctrl bresp", word_t'(RESP_OKAY), word_t'(resp));
        axi_read(REG_CTRL, 0, rdata, resp);
        check_word("ctrl readback", 32'h6, rdata);
        check_word("ctrl rresp", word_t'(RESP_OKAY), word_t'(resp));
        axi_write(REG_CTRL, 32'h0, 0, resp);
        axi_write(MSG_BASE + 14'h14, 32'h0000_f1a5, 3, resp);
        check_word("cell bresp held", word_t'(RESP_OKAY), word_t'(resp));
        axi_read(MSG_BASE + 14'h14, 3, rdata, resp);
        check_word("cell readback", 32'h1a5, rdata);
        check_word("cell rresp held", word_t'(RESP_OKAY), word_t'(resp));
        axi_write(FONT_BASE + 14'h50, 32'hdead_be5a, 0, resp);
        axi_read(FONT_BASE + 14'h50, 0, rdata, resp);
        check_word("font readback", 32'h5a, rdata);
        check_word("font rresp", word_t'(RESP_OKAY), word_t'(resp));
        axi_write(14'h3000, 32'h1, 2, resp);
        check_word("unmapped bresp", word_t'(RESP_SLVERR), word_t'(resp));
        axi_read(14'h0008, 2, rdata, resp);
        check_word("unmapped rresp", word_t'(RESP_SLVERR), word_t'(resp));
        check_word("unmapped rdata", 32'h0, rdata);

        // blank glyph everywhere, then dim the picture
        load_glyph(0, 8'h00);
        load_glyph(1, 8'hff);
        fill_cells(7'd0, 2'd0, 1'b1);
        axi_write(REG_CTRL, 32'h1, 0, resp);
        mode = M_OFF;
        wait_frame();
        mode = M_DIM;
        wait_frame();

        // solid glyph in palette 2
        mode = M_OFF;
        fill_cells(7'd1, 2'd2, 1'b0);
        wait_frame();
        mode = M_TEXT;
        for (int f = 0; f < 7; f++) begin
            wait_frame();
            axi_read(REG_STATUS, 0, pos[f], resp);
        end
        for (int f = 0; f + SPEED + 1 < 7; f++) begin
            check_word("scroll steps per window", 32'd1, pos[f + SPEED + 1] - pos[f]);
        end

        axi_write(REG_CTRL, 32'h5, 0, resp);  // enable with fast_scroll
        wait_frame();
        for (int f = 0; f < 4; f++) begin
            wait_frame();
            axi_read(REG_STATUS, 0, pos[f], resp);
        end
        for (int f = 0; f < 3; f++) begin
            check_word("fast scroll step", 32'd1, pos[f + 1] - pos[f]);
        end

        // enable edge clears the position
        mode = M_OFF;
        axi_write(REG_CTRL, 32'h0, 0, resp);
        axi_write(REG_CTRL, 32'h1, 0, resp);
        axi_read(REG_STATUS, 0, rdata, resp);
        check_word("scroll after re-enable", 32'h0, rdata);

        axi_write(REG_CTRL, 32'h3, 0, resp);  // hidden
        wait_frame();
        mode = M_PASS;
        wait_frame();
        mode = M_OFF;
        repeat (8) @(posedge clk);

        $display("errors: checks %0d, video stream %0d, back-pressure %0d",
            check_errors, stream_errors, hold_errors);
        if (check_errors + stream_errors + hold_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
credits_pkg.sv
credits_dp_ram.sv
credits_axil_regs.sv
credits_scroller.sv
credits_mixer.sv
credits_top.sv
tb_credits.sv
